//--- hdl/streamer_settings.svh
//////////////////////////////
// widths, scratchpad depth and
// offset FIFO depth
//////////////////////////////

`ifndef STREAMER_SETTINGS_SVH
`define STREAMER_SETTINGS_SVH

`define STREAMER_DATA_W    32   // stream item width
`define STREAMER_ADDR_W    12   // byte address, 4 KiB scratchpad
`define STREAMER_MEM_WORDS 1024 // 32-bit words in the scratchpad
`define STREAMER_CNT_W     10   // length and item counters

// must cover the grant to rvalid latency
`define STREAMER_OFS_DEPTH 4

`endif

//--- hdl/streamer_pkg.sv
//////////////////////////////
// shared vector types and the
// streamer FSM encoding
//////////////////////////////

`include "streamer_settings.svh"

package streamer_pkg;

  // one stream item
  typedef logic [`STREAMER_DATA_W-1:0] data_t;

  // one memory read: addressed word low, next word high
  typedef logic [2*`STREAMER_DATA_W-1:0] rdata_t;

  // byte address into the scratchpad
  typedef logic [`STREAMER_ADDR_W-1:0] addr_t;

  // job length and item count
  typedef logic [`STREAMER_CNT_W-1:0] cnt_t;

  // control plane of one source streamer
  typedef enum logic [1:0] {
    IDLE    = 2'd0, // ready_start high
    WORKING = 2'd1, // addresses still being generated
    DRAIN   = 2'd2  // waiting for the last items to leave
  } streamer_state_e;

endpackage

//--- hdl/stride_addr_gen.sv
//////////////////////////////
// strided byte-address generator
// base, stride and length
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module stride_addr_gen (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,      // abort or end of job
  input  logic                start_i,      // job launch, samples config
  input  streamer_pkg::addr_t base_i,
  input  streamer_pkg::addr_t stride_i,     // in bytes
  input  streamer_pkg::cnt_t  len_i,        // in items
  output streamer_pkg::addr_t addr_o,
  output logic                addr_valid_o,
  input  logic                addr_ready_i,
  output logic                last_o        // every address handed off
);

  streamer_pkg::addr_t addr_q;   // next address to present
  streamer_pkg::addr_t stride_q;
  streamer_pkg::cnt_t  len_q;
  streamer_pkg::cnt_t  cnt_q;    // addresses accepted so far
  logic                busy_q;
  logic                accept;

  // base goes out directly in the start cycle so the FIFO catches it
  assign addr_o       = start_i ? base_i : addr_q;
  assign addr_valid_o = start_i ? (len_i != '0) : (busy_q && (cnt_q != len_q));
  assign accept       = addr_valid_o & addr_ready_i;
  assign last_o       = busy_q & (cnt_q == len_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (start_i) begin
      busy_q <= 1'b1;
      cnt_q  <= accept ? streamer_pkg::cnt_t'(1) : '0; // base may go out at once
    end else if (accept) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // job registers, only meaningful while busy
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      stride_q <= stride_i;
      len_q    <= len_i;
      addr_q   <= accept ? base_i + stride_i : base_i;
    end else if (accept) begin
      addr_q <= addr_q + stride_q; // wraps with the address space
    end
  end

  // a presented address may not move before the FIFO takes it
  a_addr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    addr_valid_o && !addr_ready_i && !clear_i |=> $stable(addr_o)
  ) else $error("stride_addr_gen: address changed while waiting");

endmodule

//--- hdl/scratch_source.sv
//////////////////////////////
// source streamer: address FIFO,
// offset FIFO, realignment, hold
// register, item counter and FSM
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module scratch_source (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 clear_i,
  input  logic                 start_i,
  input  streamer_pkg::addr_t  base_i,
  input  streamer_pkg::addr_t  stride_i,
  input  streamer_pkg::cnt_t   len_i,
  output logic                 ready_start_o,
  output logic                 done_o,
  output logic                 mem_req_o,
  output streamer_pkg::addr_t  mem_addr_o,   // word aligned
  input  logic                 mem_gnt_i,
  input  logic                 mem_rvalid_i,
  input  streamer_pkg::rdata_t mem_rdata_i,
  output logic                 out_valid_o,
  output streamer_pkg::data_t  out_data_o,
  input  logic                 out_ready_i
);

  localparam int unsigned OFS_D  = `STREAMER_OFS_DEPTH;
  localparam int unsigned OFS_PW = $clog2(OFS_D);

  streamer_pkg::streamer_state_e cs, ns;

  streamer_pkg::addr_t  ag_addr;
  logic                 ag_valid, ag_last, ag_start, ag_clear;
  streamer_pkg::addr_t  af_mem [2];  // two-entry address FIFO
  logic                 af_wptr, af_rptr;
  logic [1:0]           af_cnt;
  logic                 af_push, af_pop, af_full, af_empty;
  streamer_pkg::addr_t  af_head;
  logic [1:0]           ofs_mem [OFS_D];
  logic [OFS_PW-1:0]    ofs_wptr, ofs_rptr;
  logic [OFS_PW:0]      ofs_cnt;
  logic                 ofs_push, ofs_pop;
  logic [1:0]           ofs_head;    // byte shift of the item in flight
  logic                 hold_valid_q;
  streamer_pkg::rdata_t hold_data_q;
  streamer_pkg::rdata_t src_data, shifted;
  streamer_pkg::cnt_t   len_q, item_cnt_q;
  logic                 xfer;

  assign ag_start = start_i & ready_start_o; // only taken in IDLE
  assign ag_clear = clear_i | done_o;

  stride_addr_gen i_addr_gen (
    .clk_i        ( clk_i    ),
    .rst_ni       ( rst_ni   ),
    .clear_i      ( ag_clear ),
    .start_i      ( ag_start ),
    .base_i       ( base_i   ),
    .stride_i     ( stride_i ),
    .len_i        ( len_i    ),
    .addr_o       ( ag_addr  ),
    .addr_valid_o ( ag_valid ),
    .addr_ready_i ( ~af_full ),
    .last_o       ( ag_last  )
  );

  assign af_full  = (af_cnt == 2'd2);
  assign af_empty = (af_cnt == 2'd0);
  assign af_head  = af_mem[af_rptr];
  assign af_push  = ag_valid & ~af_full;
  assign af_pop   = mem_req_o & mem_gnt_i; // a grant is the transfer

  // no request while the stream stalls, so one response at most is parked
  assign mem_req_o  = (cs != streamer_pkg::IDLE) & ~af_empty & out_ready_i & ~clear_i;
  assign mem_addr_o = {af_head[`STREAMER_ADDR_W-1:2], 2'b00};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      af_wptr <= 1'b0;
      af_rptr <= 1'b0;
      af_cnt  <= '0;
    end else if (clear_i) begin
      af_wptr <= 1'b0;
      af_rptr <= 1'b0;
      af_cnt  <= '0;
    end else begin
      if (af_push) af_wptr <= ~af_wptr;
      if (af_pop)  af_rptr <= ~af_rptr;
      af_cnt <= af_cnt + {1'b0, af_push} - {1'b0, af_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (af_push) af_mem[af_wptr] <= ag_addr;
  end

  assign ofs_push = af_pop;            // low address bits at grant time
  assign ofs_pop  = xfer;              // retired with the item
  assign ofs_head = ofs_mem[ofs_rptr];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ofs_wptr <= '0;
      ofs_rptr <= '0;
      ofs_cnt  <= '0;
    end else if (clear_i) begin
      ofs_wptr <= '0;
      ofs_rptr <= '0;
      ofs_cnt  <= '0;
    end else begin
      if (ofs_push) ofs_wptr <= (ofs_wptr == OFS_PW'(OFS_D-1)) ? '0 : ofs_wptr + 1'b1;
      if (ofs_pop)  ofs_rptr <= (ofs_rptr == OFS_PW'(OFS_D-1)) ? '0 : ofs_rptr + 1'b1;
      ofs_cnt <= ofs_cnt + {{OFS_PW{1'b0}}, ofs_push} - {{OFS_PW{1'b0}}, ofs_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (ofs_push) ofs_mem[ofs_wptr] <= af_head[1:0];
  end

  // double-word read, so any byte offset still holds a whole item
  assign src_data    = mem_rvalid_i ? mem_rdata_i : hold_data_q;
  assign shifted     = src_data >> {ofs_head, 3'b000};
  assign out_data_o  = shifted[`STREAMER_DATA_W-1:0];
  assign out_valid_o = mem_rvalid_i | hold_valid_q;
  assign xfer        = out_valid_o & out_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (clear_i) begin
      hold_valid_q <= 1'b0;
    end else if (mem_rvalid_i && !out_ready_i) begin
      hold_valid_q <= 1'b1;            // park the late response
    end else if (out_ready_i) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_rvalid_i && !out_ready_i) hold_data_q <= mem_rdata_i;
  end

  always_ff @(posedge clk_i) begin
    if (ag_start) len_q <= len_i;      // job length for the end check
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      item_cnt_q <= '0;
    end else if (clear_i || done_o) begin
      item_cnt_q <= '0;
    end else if (xfer) begin
      item_cnt_q <= item_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs <= streamer_pkg::IDLE;
    end else if (clear_i) begin
      cs <= streamer_pkg::IDLE;
    end else begin
      cs <= ns;
    end
  end

  always_comb begin
    ns            = cs;
    ready_start_o = 1'b0;
    done_o        = 1'b0;
    case (cs)
      streamer_pkg::IDLE: begin
        ready_start_o = 1'b1;
        if (start_i) ns = streamer_pkg::WORKING;
      end
      streamer_pkg::WORKING: begin
        if (ag_last) ns = streamer_pkg::DRAIN; // all addresses in the FIFO
      end
      streamer_pkg::DRAIN: begin
        if (af_empty && (item_cnt_q == len_q)) begin
          ns     = streamer_pkg::IDLE;
          done_o = 1'b1;
        end
      end
      default: ns = streamer_pkg::IDLE;
    endcase
  end

  a_ofs_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ofs_push |-> (ofs_cnt != (OFS_PW+1)'(OFS_D))
  ) else $error("scratch_source: offset FIFO pushed while full");

  a_rvalid_has_ofs : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_rvalid_i |-> (ofs_cnt != '0)
  ) else $error("scratch_source: response without a pending offset");

endmodule

//--- hdl/rr_mem_arbiter.sv
//////////////////////////////
// two-port round-robin arbiter
// with response routing
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module rr_mem_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic [1:0]           req_i,
  input  streamer_pkg::addr_t  addr_i0,
  input  streamer_pkg::addr_t  addr_i1,
  output logic [1:0]           gnt_o,
  output logic [1:0]           rvalid_o,
  output streamer_pkg::rdata_t rdata_o,     // shared, qualified by rvalid_o
  output logic                 mem_req_o,
  output streamer_pkg::addr_t  mem_addr_o,
  input  logic                 mem_rvalid_i,
  input  streamer_pkg::rdata_t mem_rdata_i
);

  // index of the port granted last; with a fixed one-cycle memory
  // latency it also names the owner of the response in flight
  logic last_q;

  // on a tie the port not granted last wins
  assign gnt_o[0] = req_i[0] & (~req_i[1] | last_q);
  assign gnt_o[1] = req_i[1] & (~req_i[0] | ~last_q);

  assign mem_req_o  = |req_i;
  assign mem_addr_o = gnt_o[1] ? addr_i1 : addr_i0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q <= 1'b1;              // port 0 wins the first tie
    end else if (mem_req_o) begin
      last_q <= gnt_o[1];
    end
  end

  assign rvalid_o[0] = mem_rvalid_i & ~last_q;
  assign rvalid_o[1] = mem_rvalid_i & last_q;
  assign rdata_o     = mem_rdata_i;

  // the response goes back to the port that won the grant
  a_gnt_routed : assert property (@(posedge clk_i) disable iff (!rst_ni)
    |gnt_o |=> rvalid_o == $past(gnt_o)
  ) else $error("rr_mem_arbiter: response not routed to the granted port");

  // routing relies on the memory answering exactly one cycle later
  a_mem_latency : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req_o |=> mem_rvalid_i
  ) else $error("rr_mem_arbiter: memory response not one cycle after grant");

endmodule

//--- hdl/scratch_mem.sv
//////////////////////////////
// single-ported scratchpad with
// double-word read, host load
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module scratch_mem (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 req_i,        // read only
  input  streamer_pkg::addr_t  addr_i,       // byte address, word aligned
  output logic                 rvalid_o,
  output streamer_pkg::rdata_t rdata_o,
  input  logic                 load_we_i,    // host side, wins the port
  input  streamer_pkg::addr_t  load_addr_i,  // word index
  input  streamer_pkg::data_t  load_data_i
);

  localparam int unsigned IDX_W = $clog2(`STREAMER_MEM_WORDS);

  streamer_pkg::data_t  mem_q [`STREAMER_MEM_WORDS];
  logic [IDX_W-1:0]     rd_idx, nxt_idx, ld_idx;
  logic                 rvalid_q;
  streamer_pkg::rdata_t rdata_q;

  assign rd_idx  = addr_i[IDX_W+1:2];     // drop byte offset
  assign nxt_idx = rd_idx + 1'b1;         // wraps at the top word
  assign ld_idx  = load_addr_i[IDX_W-1:0];

  always_ff @(posedge clk_i) begin
    if (load_we_i) begin
      mem_q[ld_idx] <= load_data_i;
    end
    if (req_i) begin
      rdata_q <= {mem_q[nxt_idx], mem_q[rd_idx]}; // next word in the high half
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;                  // fixed one-cycle latency
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

  // host loads only while both streamers sit idle
  a_no_load_during_read : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(load_we_i && req_i)
  ) else $error("scratch_mem: host load collides with a streamer read");

endmodule

//--- hdl/dual_source_top.sv
//////////////////////////////
// two source streamers sharing
// one scratchpad via an arbiter
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module dual_source_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                load_we_i,
  input  streamer_pkg::addr_t load_addr_i,
  input  streamer_pkg::data_t load_data_i,
  input  logic                start_a_i,
  input  streamer_pkg::addr_t base_a_i,
  input  streamer_pkg::addr_t stride_a_i,
  input  streamer_pkg::cnt_t  len_a_i,
  output logic                ready_start_a_o,
  output logic                done_a_o,
  output logic                out_valid_a_o,
  output streamer_pkg::data_t out_data_a_o,
  input  logic                out_ready_a_i,
  input  logic                start_b_i,
  input  streamer_pkg::addr_t base_b_i,
  input  streamer_pkg::addr_t stride_b_i,
  input  streamer_pkg::cnt_t  len_b_i,
  output logic                ready_start_b_o,
  output logic                done_b_o,
  output logic                out_valid_b_o,
  output streamer_pkg::data_t out_data_b_o,
  input  logic                out_ready_b_i
);

  logic [1:0]           src_req, src_gnt, src_rvalid; // bit 0 is channel a
  streamer_pkg::addr_t  src_addr_a, src_addr_b;
  streamer_pkg::rdata_t src_rdata;
  logic                 mem_req, mem_rvalid;
  streamer_pkg::addr_t  mem_addr;
  streamer_pkg::rdata_t mem_rdata;

  scratch_source i_src_a (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .clear_i       ( clear_i         ),
    .start_i       ( start_a_i       ),
    .base_i        ( base_a_i        ),
    .stride_i      ( stride_a_i      ),
    .len_i         ( len_a_i         ),
    .ready_start_o ( ready_start_a_o ),
    .done_o        ( done_a_o        ),
    .mem_req_o     ( src_req[0]      ),
    .mem_addr_o    ( src_addr_a      ),
    .mem_gnt_i     ( src_gnt[0]      ),
    .mem_rvalid_i  ( src_rvalid[0]   ),
    .mem_rdata_i   ( src_rdata       ),
    .out_valid_o   ( out_valid_a_o   ),
    .out_data_o    ( out_data_a_o    ),
    .out_ready_i   ( out_ready_a_i   )
  );

  scratch_source i_src_b (
    .clk_i         ( clk_i           ),
    .rst_ni        ( rst_ni          ),
    .clear_i       ( clear_i         ),
    .start_i       ( start_b_i       ),
    .base_i        ( base_b_i        ),
    .stride_i      ( stride_b_i      ),
    .len_i         ( len_b_i         ),
    .ready_start_o ( ready_start_b_o ),
    .done_o        ( done_b_o        ),
    .mem_req_o     ( src_req[1]      ),
    .mem_addr_o    ( src_addr_b      ),
    .mem_gnt_i     ( src_gnt[1]      ),
    .mem_rvalid_i  ( src_rvalid[1]   ),
    .mem_rdata_i   ( src_rdata       ),
    .out_valid_o   ( out_valid_b_o   ),
    .out_data_o    ( out_data_b_o    ),
    .out_ready_i   ( out_ready_b_i   )
  );

  rr_mem_arbiter i_arb (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .req_i        ( src_req    ),
    .addr_i0      ( src_addr_a ),
    .addr_i1      ( src_addr_b ),
    .gnt_o        ( src_gnt    ),
    .rvalid_o     ( src_rvalid ),
    .rdata_o      ( src_rdata  ),
    .mem_req_o    ( mem_req    ),
    .mem_addr_o   ( mem_addr   ),
    .mem_rvalid_i ( mem_rvalid ),
    .mem_rdata_i  ( mem_rdata  )
  );

  scratch_mem i_mem (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_i       ( mem_req     ),
    .addr_i      ( mem_addr    ),
    .rvalid_o    ( mem_rvalid  ),
    .rdata_o     ( mem_rdata   ),
    .load_we_i   ( load_we_i   ),
    .load_addr_i ( load_addr_i ),
    .load_data_i ( load_data_i )
  );

endmodule

//--- test/tb_dual_source.sv
//////////////////////////////
// testbench for the dual source
// streamer: preload, jobs, random
// back-pressure, clear, checkers
//////////////////////////////

`timescale 1ns/1ps

`include "streamer_settings.svh"

module tb_dual_source;

  logic                clk_i, rst_ni, clear, clear_q;
  logic                load_we;
  streamer_pkg::addr_t load_addr;
  streamer_pkg::data_t load_data;
  logic                start_a, start_b, ready_start_a, ready_start_b;
  streamer_pkg::addr_t base_a, stride_a, base_b, stride_b;
  streamer_pkg::cnt_t  len_a, len_b;
  logic                done_a, done_b, out_valid_a, out_valid_b, out_ready_a, out_ready_b;
  streamer_pkg::data_t out_data_a, out_data_b;

  logic [7:0]          img [4096];     // byte view of the scratchpad
  streamer_pkg::data_t exp_a [$];      // items still owed per channel
  streamer_pkg::data_t exp_b [$];
  streamer_pkg::data_t head_a, head_b, prev_a, prev_b;
  int                  cnt_a, cnt_b;
  logic                active_a, active_b; // job started, done not yet seen
  logic                bp_on;          // random out_ready when set
  int                  seed = 6;

  dual_source_top dual_source_top_i (
    .clk_i (clk_i), .rst_ni (rst_ni), .clear_i (clear),
    .load_we_i (load_we), .load_addr_i (load_addr), .load_data_i (load_data),
    .start_a_i (start_a), .base_a_i (base_a), .stride_a_i (stride_a), .len_a_i (len_a),
    .ready_start_a_o (ready_start_a), .done_a_o (done_a),
    .out_valid_a_o (out_valid_a), .out_data_a_o (out_data_a), .out_ready_a_i (out_ready_a),
    .start_b_i (start_b), .base_b_i (base_b), .stride_b_i (stride_b), .len_b_i (len_b),
    .ready_start_b_o (ready_start_b), .done_b_o (done_b),
    .out_valid_b_o (out_valid_b), .out_data_b_o (out_data_b), .out_ready_b_i (out_ready_b)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;         // 8 ns period
  end

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  // word pattern spreads every address bit over the data
  function automatic streamer_pkg::data_t fill_word(input int j);
    return ((j + 1) * 32'h9E37_79B1) ^ (j << 21) ^ 32'h0F0F_5A5A;
  endfunction

  // four bytes from a byte address, little-endian, wrapping at the top
  function automatic streamer_pkg::data_t item_at(input int a);
    return {img[(a + 3) & 4095], img[(a + 2) & 4095], img[(a + 1) & 4095], img[a & 4095]};
  endfunction

  task automatic refresh_heads();
    cnt_a  = exp_a.size();
    cnt_b  = exp_b.size();
    head_a = (cnt_a > 0) ? exp_a[0] : '0;
    head_b = (cnt_b > 0) ? exp_b[0] : '0;
  endtask

  // retire transferred items and finished jobs
  always @(posedge clk_i) begin
    prev_a  = out_data_a;
    prev_b  = out_data_b;
    clear_q = clear;
    if (rst_ni && !clear) begin
      if (out_valid_a && out_ready_a && exp_a.size() > 0) void'(exp_a.pop_front());
      if (out_valid_b && out_ready_b && exp_b.size() > 0) void'(exp_b.pop_front());
      if (done_a) active_a = 1'b0;
      if (done_b) active_b = 1'b0;
    end
    refresh_heads();
  end

  a_idle_a : assert property (@(posedge clk_i)
    !rst_ni || $rose(rst_ni) || clear_q |-> ready_start_a && !out_valid_a && !done_a
  ) else abort_run("channel a not idle after reset or clear");
  a_idle_b : assert property (@(posedge clk_i)
    !rst_ni || $rose(rst_ni) || clear_q |-> ready_start_b && !out_valid_b && !done_b
  ) else abort_run("channel b not idle after reset or clear");

  a_data_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_a && out_ready_a |-> out_data_a == head_a
  ) else report_mismatch("out_data_a", $sampled(out_data_a), $sampled(head_a));
  a_data_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_b && out_ready_b |-> out_data_b == head_b
  ) else report_mismatch("out_data_b", $sampled(out_data_b), $sampled(head_b));

  a_extra_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_a && out_ready_a |-> cnt_a > 0
  ) else abort_run("channel a delivered more items than its job holds");
  a_extra_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_b && out_ready_b |-> cnt_b > 0
  ) else abort_run("channel b delivered more items than its job holds");

  // stalled item stays put until it is taken
  a_vhold_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_a && !out_ready_a |=> out_valid_a
  ) else abort_run("out_valid_a dropped before its transfer");
  a_vhold_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_b && !out_ready_b |=> out_valid_b
  ) else abort_run("out_valid_b dropped before its transfer");
  a_dhold_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_a && !out_ready_a |=> out_data_a == prev_a
  ) else report_mismatch("out_data_a", $sampled(out_data_a), $sampled(prev_a));
  a_dhold_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    out_valid_b && !out_ready_b |=> out_data_b == prev_b
  ) else report_mismatch("out_data_b", $sampled(out_data_b), $sampled(prev_b));

  // one done per job, only once every item has left
  a_done_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    done_a |-> active_a && cnt_a == 0
  ) else abort_run("done_a pulsed early, twice, or with items missing");
  a_done_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    done_b |-> active_b && cnt_b == 0
  ) else abort_run("done_b pulsed early, twice, or with items missing");
  a_rs_a : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    done_a |=> ready_start_a
  ) else abort_run("ready_start_a low in the cycle after done_a");
  a_rs_b : assert property (@(posedge clk_i) disable iff (!rst_ni || clear)
    done_b |=> ready_start_b
  ) else abort_run("ready_start_b low in the cycle after done_b");

  task automatic step();
    @(posedge clk_i);
    #1;
    out_ready_a = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
    out_ready_b = bp_on ? (($random(seed) & 3) != 0) : 1'b1;
  endtask

  task automatic preload();
    int j;
    for (j = 0; j < `STREAMER_MEM_WORDS; j++) begin
      load_we   = 1'b1;
      load_addr = streamer_pkg::addr_t'(j);
      load_data = fill_word(j);
      {img[4*j+3], img[4*j+2], img[4*j+1], img[4*j]} = fill_word(j);
      step();
    end
    load_we = 1'b0;
  endtask

  // set up the job inputs and the items the channel owes
  task automatic queue_job(input bit ch, input int base, input int stride, input int len);
    int k;
    for (k = 0; k < len; k++) begin
      if (ch) exp_b.push_back(item_at(base + k * stride));
      else    exp_a.push_back(item_at(base + k * stride));
    end
    if (ch) begin
      base_b   = streamer_pkg::addr_t'(base);
      stride_b = streamer_pkg::addr_t'(stride);
      len_b    = streamer_pkg::cnt_t'(len);
      active_b = 1'b1;
    end else begin
      base_a   = streamer_pkg::addr_t'(base);
      stride_a = streamer_pkg::addr_t'(stride);
      len_a    = streamer_pkg::cnt_t'(len);
      active_a = 1'b1;
    end
    refresh_heads();
  endtask

  task automatic fire(input bit on_a, input bit on_b);
    int t;
    t = 0;
    while ((on_a && !ready_start_a) || (on_b && !ready_start_b)) begin
      step();
      t++;
      if (t > 100) abort_run("streamer never became ready to start");
    end
    start_a = on_a;
    start_b = on_b;
    step();                            // one-cycle start pulse
    start_a = 1'b0;
    start_b = 1'b0;
  endtask

  task automatic wait_jobs();
    int t;
    t = 0;
    while (active_a || active_b) begin
      step();
      t++;
      if (t > 4000) abort_run("a job did not signal done in time");
    end
  endtask

  initial begin
    int n, ofs, t, rb, rs, rl;
    rst_ni = 1'b0;
    clear = 1'b0;
    clear_q = 1'b0;
    load_we = 1'b0;
    load_addr = '0;
    load_data = '0;
    start_a = 1'b0;
    start_b = 1'b0;
    base_a = '0;
    stride_a = '0;
    len_a = '0;
    base_b = '0;
    stride_b = '0;
    len_b = '0;
    out_ready_a = 1'b1;
    out_ready_b = 1'b1;
    bp_on = 1'b0;
    active_a = 1'b0;
    active_b = 1'b0;
    refresh_heads();
    repeat (2) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    preload();
    queue_job(0, 64, 4, 16);           // aligned, channel a alone
    fire(1, 0);
    wait_jobs();
    for (ofs = 1; ofs < 4; ofs++) begin
      queue_job(0, 256 * ofs + ofs, 4 + ofs, 12);
      queue_job(1, 2048 + ofs, 8 - ofs, 10);
      fire(1, 1);
      wait_jobs();
    end
    queue_job(0, 4093, 4, 3);          // reads across the top of memory
    queue_job(1, 4090, 2, 5);
    fire(1, 1);
    wait_jobs();
    bp_on = 1'b1;
    for (n = 0; n < 8; n++) begin
      rb = $random(seed) & 4095;
      rs = ($random(seed) & 63) + 1;
      rl = ($random(seed) & 31) + 1;
      queue_job(0, rb, rs, rl);
      rb = $random(seed) & 4095;
      rs = ($random(seed) & 63) + 1;
      rl = ($random(seed) & 31) + 1;
      queue_job(1, rb, rs, rl);
      if (n % 2 == 0) begin
        fire(1, 1);
      end else begin
        fire(1, 0);                    // staggered launch
        fire(0, 1);
      end
      wait_jobs();
    end
    queue_job(0, 100, 4, 40);
    queue_job(1, 300, 3, 40);
    fire(1, 1);
    t = 0;
    while (cnt_a > 30) begin
      step();
      t++;
      if (t > 500) abort_run("channel a made no progress before clear");
    end
    clear = 1'b1;                      // abort both jobs mid-flight
    exp_a.delete();
    exp_b.delete();
    active_a = 1'b0;
    active_b = 1'b0;
    refresh_heads();
    step();
    clear = 1'b0;
    step();
    queue_job(0, 7, 9, 20);
    queue_job(1, 1001, 13, 20);
    fire(1, 1);
    wait_jobs();
    $display("All tests passed!");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+hdl
hdl/streamer_pkg.sv
hdl/stride_addr_gen.sv
hdl/scratch_source.sv
hdl/rr_mem_arbiter.sv
hdl/scratch_mem.sv
hdl/dual_source_top.sv
test/tb_dual_source.sv

//--- Bender.yml
package:
  name: dual_source

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/streamer_pkg.sv
      - hdl/stride_addr_gen.sv
      - hdl/scratch_source.sv
      - hdl/rr_mem_arbiter.sv
      - hdl/scratch_mem.sv
      - hdl/dual_source_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/tb_dual_source.sv
